// ==== files.f ====
logic/arith_pkg.sv
logic/engine_if.sv
logic/cmd_regs.sv
logic/mul_digit.sv
logic/div_restoring.sv
logic/arith_top.sv
verif/tb_clock.sv
verif/arith_properties.sv
verif/arith_tb.sv

// ==== logic/arith_pkg.sv ====
`default_nettype none

package arith_pkg;

    localparam int word_w = 32;
    localparam int digit_w = 8;
    localparam int digits = word_w / digit_w;

    typedef logic [word_w-1:0] word_t;
    typedef logic [digit_w-1:0] digit_t;
    typedef logic [5:0] count_t; // Holds 0 to word_w inclusive

    typedef enum logic [1:0] {
        OP_MUL,
        OP_DIVU,
        OP_DIVS,
        OP_REMU
    } op_t;

    typedef enum logic [1:0] {
        DIV_UNSIGNED,
        DIV_SIGNED,
        DIV_REMAINDER
    } div_mode_t;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE
    } mul_state_t;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_LOAD,
        DIV_RUN,
        DIV_FIX
    } div_state_t;

endpackage

`default_nettype wire

// ==== logic/arith_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module arith_top (
    input wire clk,
    input wire rst,
    input wire cmd_valid,
    input wire arith_pkg::op_t cmd_op,
    input wire arith_pkg::word_t cmd_a,
    input wire arith_pkg::word_t cmd_b,
    output logic busy,
    output logic res_valid,
    output arith_pkg::word_t res_data
);

    arith_pkg::div_mode_t div_mode;

    engine_if mul_bus ();
    engine_if div_bus ();

    cmd_regs u_cmd_regs (
        .clk(clk),
        .rst(rst),
        .cmd_valid(cmd_valid),
        .cmd_op(cmd_op),
        .cmd_a(cmd_a),
        .cmd_b(cmd_b),
        .busy(busy),
        .res_valid(res_valid),
        .res_data(res_data),
        .mul_bus(mul_bus.ctrl),
        .div_bus(div_bus.ctrl),
        .div_mode(div_mode)
    );

    mul_digit u_mul_digit (
        .clk(clk),
        .rst(rst),
        .bus(mul_bus.unit)
    );

    div_restoring u_div_restoring (
        .clk(clk),
        .rst(rst),
        .bus(div_bus.unit),
        .div_mode(div_mode)
    );

endmodule

`default_nettype wire

// ==== logic/cmd_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_regs (
    input wire clk,
    input wire rst,
    input wire cmd_valid,
    input wire arith_pkg::op_t cmd_op,
    input wire arith_pkg::word_t cmd_a,
    input wire arith_pkg::word_t cmd_b,
    output logic busy,
    output logic res_valid,
    output arith_pkg::word_t res_data,
    engine_if.ctrl mul_bus,
    engine_if.ctrl div_bus,
    output arith_pkg::div_mode_t div_mode
);

    arith_pkg::op_t op_q;
    arith_pkg::word_t a_q;
    arith_pkg::word_t b_q;
    logic mul_start;
    logic div_start;
    logic accept;
    logic sel_done;
    arith_pkg::word_t sel_result;

    assign accept = cmd_valid && !busy; // Commands seen while busy are dropped

    assign sel_done = (op_q == arith_pkg::OP_MUL) ? mul_bus.done : div_bus.done;
    assign sel_result = (op_q == arith_pkg::OP_MUL) ? mul_bus.result : div_bus.result;

    assign mul_bus.start = mul_start;
    assign mul_bus.a = a_q;
    assign mul_bus.b = b_q;
    assign div_bus.start = div_start;
    assign div_bus.a = a_q;
    assign div_bus.b = b_q;

    always_comb begin
        case (op_q)
            arith_pkg::OP_DIVS: div_mode = arith_pkg::DIV_SIGNED;
            arith_pkg::OP_REMU: div_mode = arith_pkg::DIV_REMAINDER;
            default: div_mode = arith_pkg::DIV_UNSIGNED;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            res_valid <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
            op_q <= arith_pkg::OP_MUL;
        end else begin
            mul_start <= 1'b0;
            div_start <= 1'b0;
            res_valid <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                op_q <= cmd_op;
                mul_start <= (cmd_op == arith_pkg::OP_MUL);
                div_start <= (cmd_op != arith_pkg::OP_MUL);
            end else if (res_valid) begin
                busy <= 1'b0; // Release one cycle after the result
            end else if (busy && sel_done) begin
                res_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            a_q <= cmd_a;
            b_q <= cmd_b;
        end
        if (busy && sel_done) begin
            res_data <= sel_result;
        end
    end

endmodule

`default_nettype wire

// ==== logic/div_restoring.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_restoring (
    input wire clk,
    input wire rst,
    engine_if.unit bus,
    input wire arith_pkg::div_mode_t div_mode
);

    arith_pkg::div_state_t state;
    arith_pkg::div_mode_t mode;
    arith_pkg::word_t quot; // Dividend shifts out as quotient shifts in
    arith_pkg::word_t divisor;
    arith_pkg::word_t rem;
    arith_pkg::count_t iter;
    logic neg;
    logic [arith_pkg::word_w:0] trial;
    logic is_signed;

    assign is_signed = (mode == arith_pkg::DIV_SIGNED);
    assign trial = {rem, quot[arith_pkg::word_w-1]} - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arith_pkg::DIV_IDLE;
        end else begin
            case (state)
                arith_pkg::DIV_IDLE: begin
                    if (bus.start) begin
                        state <= arith_pkg::DIV_LOAD;
                    end
                end
                arith_pkg::DIV_LOAD: state <= arith_pkg::DIV_RUN;
                arith_pkg::DIV_RUN: begin
                    if (iter == arith_pkg::count_t'(1)) begin
                        state <= arith_pkg::DIV_FIX;
                    end
                end
                default: state <= arith_pkg::DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            arith_pkg::DIV_IDLE: begin
                if (bus.start) begin
                    quot <= bus.a;
                    divisor <= bus.b;
                    mode <= div_mode;
                end
            end
            arith_pkg::DIV_LOAD: begin
                if (is_signed && quot[arith_pkg::word_w-1]) begin
                    quot <= -quot;
                end
                if (is_signed && divisor[arith_pkg::word_w-1]) begin
                    divisor <= -divisor;
                end
                neg <= is_signed && (quot[arith_pkg::word_w-1] ^ divisor[arith_pkg::word_w-1]);
                rem <= '0;
                iter <= arith_pkg::count_t'(arith_pkg::word_w);
            end
            arith_pkg::DIV_RUN: begin
                if (trial[arith_pkg::word_w]) begin
                    // Borrow, keep the shifted remainder
                    rem <= {rem[arith_pkg::word_w-2:0], quot[arith_pkg::word_w-1]};
                    quot <= {quot[arith_pkg::word_w-2:0], 1'b0};
                end else begin
                    rem <= trial[arith_pkg::word_w-1:0];
                    quot <= {quot[arith_pkg::word_w-2:0], 1'b1};
                end
                iter <= iter - 1'b1;
            end
            default: ;
        endcase
    end

    // Sign fix and remainder select, stable until the next start
    assign bus.result = (mode == arith_pkg::DIV_REMAINDER) ? rem : (neg ? -quot : quot);
    assign bus.done = (state == arith_pkg::DIV_FIX);

endmodule

`default_nettype wire

// ==== logic/engine_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface engine_if;

    logic start; // One-cycle request pulse
    arith_pkg::word_t a;
    arith_pkg::word_t b;
    arith_pkg::word_t result; // Held from done until next start
    logic done; // One-cycle completion pulse

    modport ctrl (
        output start,
        output a,
        output b,
        input result,
        input done
    );

    modport unit (
        input start,
        input a,
        input b,
        output result,
        output done
    );

endinterface

`default_nettype wire

// ==== logic/mul_digit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_digit (
    input wire clk,
    input wire rst,
    engine_if.unit bus
);

    arith_pkg::mul_state_t state;
    arith_pkg::word_t a_reg;
    arith_pkg::word_t b_reg;
    arith_pkg::word_t acc;
    arith_pkg::count_t step;
    arith_pkg::count_t apos;
    arith_pkg::count_t bpos;
    arith_pkg::digit_t a_digit;
    arith_pkg::digit_t b_digit;
    logic [2*arith_pkg::digit_w-1:0] prod;
    arith_pkg::word_t shifted;
    logic last_step;

    assign apos = step % arith_pkg::count_t'(arith_pkg::digits);
    assign bpos = step / arith_pkg::count_t'(arith_pkg::digits);
    assign last_step = (step == arith_pkg::count_t'(arith_pkg::digits * arith_pkg::digits - 1));

    // Low digit of each operand is the one in use this cycle
    assign a_digit = a_reg[arith_pkg::digit_w-1:0];
    assign b_digit = b_reg[arith_pkg::digit_w-1:0];
    assign prod = {{arith_pkg::digit_w{1'b0}}, a_digit} * {{arith_pkg::digit_w{1'b0}}, b_digit};

    // Positions at or past word_w shift out entirely
    assign shifted = arith_pkg::word_t'(prod) << ((apos + bpos) * arith_pkg::digit_w);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arith_pkg::MUL_IDLE;
        end else begin
            case (state)
                arith_pkg::MUL_IDLE: begin
                    if (bus.start) begin
                        state <= arith_pkg::MUL_RUN;
                    end
                end
                arith_pkg::MUL_RUN: begin
                    if (last_step) begin
                        state <= arith_pkg::MUL_DONE;
                    end
                end
                default: state <= arith_pkg::MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == arith_pkg::MUL_IDLE && bus.start) begin
            a_reg <= bus.a;
            b_reg <= bus.b;
            acc <= '0;
            step <= '0;
        end else if (state == arith_pkg::MUL_RUN) begin
            acc <= acc + shifted;
            step <= step + 1'b1;
            a_reg <= {a_reg[arith_pkg::digit_w-1:0], a_reg[arith_pkg::word_w-1:arith_pkg::digit_w]};
            if (apos == arith_pkg::count_t'(arith_pkg::digits - 1)) begin
                // b advances once a has cycled through all its digits
                b_reg <= {b_reg[arith_pkg::digit_w-1:0],
                          b_reg[arith_pkg::word_w-1:arith_pkg::digit_w]};
            end
        end
    end

    assign bus.done = (state == arith_pkg::MUL_DONE);
    assign bus.result = acc;

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the arithmetic unit simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f files.f --top-module arith_tb -o arith_sim \
    || { echo "Build failed"; exit 1; }

sim_out="$(./obj_dir/arith_sim +verilator+error+limit+1000)"
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "STATUS: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== verif/arith_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module arith_properties (
    input wire clk,
    input wire rst,
    input wire busy,
    input wire res_valid,
    input wire mul_start,
    input wire mul_done,
    input wire div_start,
    input wire div_done,
    input wire arith_pkg::mul_state_t mul_state,
    input wire arith_pkg::div_state_t div_state
);

    int fail_count = 0; // Read by the testbench summary

    res_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        res_valid |=> !res_valid)
    else begin
        fail_count++;
        $error("res_valid stayed high for more than one cycle");
    end

    mul_start_idle: assert property (@(posedge clk) disable iff (rst)
        mul_start |-> (mul_state == arith_pkg::MUL_IDLE))
    else begin
        fail_count++;
        $error("multiplier started while it was still running");
    end

    div_start_idle: assert property (@(posedge clk) disable iff (rst)
        div_start |-> (div_state == arith_pkg::DIV_IDLE))
    else begin
        fail_count++;
        $error("divider started while it was still running");
    end

    mul_done_apart: assert property (@(posedge clk) disable iff (rst)
        !(mul_start && mul_done))
    else begin
        fail_count++;
        $error("multiplier done in the same cycle as its start");
    end

    div_done_apart: assert property (@(posedge clk) disable iff (rst)
        !(div_start && div_done))
    else begin
        fail_count++;
        $error("divider done in the same cycle as its start");
    end

    busy_release: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> $past(res_valid))
    else begin
        fail_count++;
        $error("busy fell without a preceding res_valid");
    end

endmodule

bind arith_top arith_properties props (
    .clk(clk),
    .rst(rst),
    .busy(busy),
    .res_valid(res_valid),
    .mul_start(mul_bus.start),
    .mul_done(mul_bus.done),
    .div_start(div_bus.start),
    .div_done(div_bus.done),
    .mul_state(u_mul_digit.state),
    .div_state(u_div_restoring.state)
);

`default_nettype wire

// ==== verif/arith_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module arith_tb;

    logic clk;
    logic rst;
    logic cmd_valid;
    arith_pkg::op_t cmd_op;
    arith_pkg::word_t cmd_a;
    arith_pkg::word_t cmd_b;
    logic busy;
    logic res_valid;
    arith_pkg::word_t res_data;

    logic [31:0] lfsr;
    int checks;
    int errors;
    int timeouts;
    bit timed_out;

    tb_clock u_clock (
        .clk(clk),
        .rst(rst)
    );

    arith_top DUT (
        .clk(clk),
        .rst(rst),
        .cmd_valid(cmd_valid),
        .cmd_op(cmd_op),
        .cmd_a(cmd_a),
        .cmd_b(cmd_b),
        .busy(busy),
        .res_valid(res_valid),
        .res_data(res_data)
    );

    // Galois form of x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'hA300_0000;
        end
        return n;
    endfunction

    function automatic arith_pkg::word_t take_bits(input int n);
        arith_pkg::word_t v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic arith_pkg::word_t model_result(
        input arith_pkg::op_t op,
        input arith_pkg::word_t a,
        input arith_pkg::word_t b
    );
        logic [63:0] full;
        arith_pkg::word_t ma;
        arith_pkg::word_t mb;
        arith_pkg::word_t q;
        full = {32'd0, a} * {32'd0, b};
        ma = a[31] ? -a : a;
        mb = b[31] ? -b : b;
        case (op)
            arith_pkg::OP_MUL: q = full[31:0];
            arith_pkg::OP_DIVU: q = (b == '0) ? '1 : a / b;
            arith_pkg::OP_REMU: q = (b == '0) ? a : a % b;
            default: begin
                q = (mb == '0) ? '1 : ma / mb; // Truncates toward zero on magnitudes
                q = (a[31] ^ b[31]) ? -q : q;
            end
        endcase
        return q;
    endfunction

    task automatic check_value(input string name, input arith_pkg::word_t expected,
                               input arith_pkg::word_t actual);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input bit ok, input string name, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            $display("%s failed: %s", name, what);
        end
    endtask

    task automatic wait_not_busy(input string name);
        int cycles;
        bit idle;
        cycles = 0;
        idle = 1'b0;
        while (!timed_out && !idle) begin
            @(negedge clk);
            if (!busy) begin
                idle = 1'b1;
            end else begin
                cycles++;
                if (cycles > 100) begin
                    $display("Timeout in %s: busy stayed high for 100 cycles", name);
                    timeouts++;
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    task automatic wait_result(input string name, output arith_pkg::word_t data);
        int cycles;
        bit got;
        cycles = 0;
        got = 1'b0;
        data = '0;
        while (!timed_out && !got) begin
            @(negedge clk);
            if (res_valid) begin
                data = res_data;
                got = 1'b1;
            end else begin
                cycles++;
                if (cycles > 100) begin // Slowest engine needs about 40
                    $display("Timeout in %s: no res_valid within 100 cycles", name);
                    timeouts++;
                    timed_out = 1'b1;
                end
            end
        end
    endtask

    task automatic run_cmd(input string name, input arith_pkg::op_t op,
                           input arith_pkg::word_t a, input arith_pkg::word_t b);
        arith_pkg::word_t got;
        wait_not_busy(name);
        if (!timed_out) begin
            cmd_valid = 1'b1;
            cmd_op = op;
            cmd_a = a;
            cmd_b = b;
            @(negedge clk);
            cmd_valid = 1'b0;
            wait_result(name, got);
        end
        if (!timed_out) begin
            check_value(name, model_result(op, a, b), got);
        end
    endtask

    task automatic test_reset_state();
        int cycles;
        int i;
        cycles = 0;
        while (!timed_out && rst !== 1'b0) begin
            @(negedge clk);
            check_flag(!busy && !res_valid, "reset_state", "busy or res_valid high in reset");
            cycles++;
            if (cycles > 20) begin
                $display("Timeout in reset_state: reset never released");
                timeouts++;
                timed_out = 1'b1;
            end
        end
        for (i = 0; i < 5 && !timed_out; i++) begin
            @(negedge clk);
            check_flag(!busy && !res_valid, "reset_state",
                       "busy or res_valid rose after reset without a command");
        end
    endtask

    task automatic test_mul_random();
        arith_pkg::word_t a;
        arith_pkg::word_t b;
        int i;
        for (i = 0; i < 40; i++) begin
            a = take_bits(32);
            b = take_bits(32);
            run_cmd("mul_random", arith_pkg::OP_MUL, a, b);
        end
    endtask

    task automatic test_div_random();
        arith_pkg::word_t a;
        arith_pkg::word_t b;
        int i;
        for (i = 0; i < 40; i++) begin
            a = take_bits(32);
            b = take_bits(1 + int'(take_bits(5))); // Mix of small and wide divisors
            if (b == '0) begin
                b = 32'd1;
            end
            run_cmd("divu_random", arith_pkg::OP_DIVU, a, b);
            run_cmd("divu_random", arith_pkg::OP_REMU, a, b);
        end
    endtask

    task automatic test_divs_signs();
        arith_pkg::word_t a;
        arith_pkg::word_t b;
        int s;
        int i;
        for (s = 0; s < 4; s++) begin
            run_cmd("divs_signs", arith_pkg::OP_DIVS,
                    s[1] ? arith_pkg::word_t'(-7) : 32'd7,
                    s[0] ? arith_pkg::word_t'(-2) : 32'd2);
            for (i = 0; i < 8; i++) begin
                a = take_bits(31);
                b = take_bits(1 + int'(take_bits(4)));
                if (b == '0) begin
                    b = 32'd1;
                end
                run_cmd("divs_signs", arith_pkg::OP_DIVS, s[1] ? -a : a, s[0] ? -b : b);
            end
        end
    endtask

    task automatic test_div_by_zero();
        arith_pkg::word_t a;
        int i;
        for (i = 0; i < 8; i++) begin
            case (i)
                0: a = 32'h1234_5678;
                1: a = 32'h8000_0005;
                default: a = take_bits(32);
            endcase
            run_cmd("div_by_zero", arith_pkg::OP_DIVU, a, '0);
            run_cmd("div_by_zero", arith_pkg::OP_REMU, a, '0);
            run_cmd("div_by_zero", arith_pkg::OP_DIVS, a, '0);
        end
    endtask

    task automatic test_busy_ignore();
        arith_pkg::word_t a;
        arith_pkg::word_t b;
        arith_pkg::word_t got;
        int i;
        a = take_bits(32);
        b = take_bits(32);
        got = '0;
        wait_not_busy("busy_ignore");
        if (!timed_out) begin
            cmd_valid = 1'b1;
            cmd_op = arith_pkg::OP_MUL;
            cmd_a = a;
            cmd_b = b;
            @(negedge clk);
            // Overlapping command while the multiply runs
            cmd_op = arith_pkg::OP_DIVU;
            cmd_a = ~a;
            cmd_b = 32'd3;
            for (i = 0; i < 4; i++) begin
                check_flag(busy, "busy_ignore", "busy was low while a second command was driven");
                @(negedge clk);
            end
            cmd_valid = 1'b0;
            wait_result("busy_ignore", got);
        end
        if (!timed_out) begin
            check_value("busy_ignore", model_result(arith_pkg::OP_MUL, a, b), got);
            for (i = 0; i < 60; i++) begin
                @(negedge clk);
                check_flag(!res_valid && !busy, "busy_ignore",
                           "the dropped command was executed");
            end
        end
    endtask

    initial begin
        cmd_valid = 1'b0;
        cmd_op = arith_pkg::OP_MUL;
        cmd_a = '0;
        cmd_b = '0;
        lfsr = 32'd69;
        checks = 0;
        errors = 0;
        timeouts = 0;
        timed_out = 1'b0;

        test_reset_state();
        test_mul_random();
        test_div_random();
        test_divs_signs();
        test_div_by_zero();
        test_busy_ignore();

        $display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
                 checks, errors, timeouts, DUT.props.fail_count);
        if (errors == 0 && timeouts == 0 && DUT.props.fail_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk; // 10 ns period
        end
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst <= 1'b0; // Released on a falling edge like the other inputs
    end

endmodule

`default_nettype wire
